// ==== build.f ====
verilog/cpu_bus_pkg.sv
verilog/io_regs_pkg.sv
verilog/cpu_bus_ctrl.sv
verilog/via_gpio.sv
verilog/sys_regs.sv
verilog/nora_io_top.sv
sim/nora_io_assert.sv
sim/nora_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the nora_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module nora_io_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vnora_io_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
    exit 0
else
    exit 1
fi

// ==== sim/nora_io_assert.sv ====
/* bound checker for nora_io_top with shadow registers kept from observed bus writes
   concurrent assertions on phase timing, gpio, bank, irq and read data */
`timescale 1ns/1ps

module nora_io_assert #(
    parameter logic [7:0]         IO_PAGE        = 8'h9F,
    parameter logic [3:0]         GPIO_BASE      = 4'h0,
    parameter logic [3:0]         SYS_BASE       = 4'h5,
    parameter io_regs_pkg::bank_t BANKMASK_RESET = 8'h7F
) (
    input logic                    clk6x,
    input logic                    reset_i,
    input logic                    run_i,
    input cpu_bus_pkg::cpu_addr_t  cpu_addr_i,
    input logic                    cpu_rwn_i,
    input cpu_bus_pkg::cpu_data_t  cpu_data_i,
    input cpu_bus_pkg::cpu_data_t  cpu_data_o,
    input logic                    cpu_data_oe_o,
    input logic                    cphi2_o,
    input io_regs_pkg::gpio_port_t port_a_i,
    input io_regs_pkg::gpio_port_t port_b_i,
    input io_regs_pkg::gpio_port_t port_a_o,
    input io_regs_pkg::gpio_port_t port_b_o,
    input io_regs_pkg::gpio_port_t port_a_oe_o,
    input io_regs_pkg::gpio_port_t port_b_oe_o,
    input logic                    ext_irqn_i,
    input logic                    cpu_irqn_o,
    input io_regs_pkg::bank_t      mem_bank_o
);
    import cpu_bus_pkg::*;
    import io_regs_pkg::*;

    int         err_cnt = 0;        // read by the testbench at the end
    int         hi_cnt;             // 0 in PH_3, 1 in PH_4, 2 in PH_5
    int         lo_cnt;             // 3 at the rising cphi2 when not stalled
    logic       cphi2_q;
    logic       rst_q;
    logic       run_all;            // run stayed high through the low stretch
    logic       in_page;
    logic       win_gpio;
    logic       win_sys;
    gpio_port_t sh_ora;
    gpio_port_t sh_orb;
    gpio_port_t sh_ddra;
    gpio_port_t sh_ddrb;
    bank_t      sh_bank;
    bank_t      sh_mask;
    cpu_data_t  sh_irq;
    cpu_data_t  sh_scratch;

    assign in_page  = (cpu_addr_i[15:8] == IO_PAGE);
    assign win_gpio = in_page && (cpu_addr_i[7:4] == GPIO_BASE);
    assign win_sys  = in_page && (cpu_addr_i[7:4] == SYS_BASE) && !win_gpio;

    // expected read byte with pins on input bits and register on output bits
    function automatic cpu_data_t exp_read(input logic [3:0] off);
        cpu_data_t v;
        v = 8'hFF;
        if (win_gpio)
        begin
            case (off)
                4'h0: v = (sh_orb & sh_ddrb) | (port_b_i & ~sh_ddrb);
                4'h1: v = (sh_ora & sh_ddra) | (port_a_i & ~sh_ddra);
                4'h2: v = sh_ddrb;
                4'h3: v = sh_ddra;
                default: v = 8'hFF;
            endcase
        end
        else if (win_sys)
        begin
            case (off)
                4'h0: v = sh_bank;
                4'h1: v = sh_mask;
                4'h2: v = sh_irq;
                4'h3: v = sh_scratch;
                default: v = 8'hFF;
            endcase
        end
        return v;
    endfunction

    always_ff @(posedge clk6x)
    begin
        rst_q   <= reset_i;
        cphi2_q <= cphi2_o;
        hi_cnt  <= cphi2_o ? hi_cnt + 1 : 0;
        lo_cnt  <= cphi2_o ? 0 : lo_cnt + 1;
        run_all <= cphi2_o ? 1'b1 : (run_all & run_i);
        if (reset_i)
        begin
            lo_cnt  <= 0;           // first low stretch starts at reset release
            run_all <= 1'b1;
            sh_ora  <= 8'h00;
            sh_orb  <= 8'h00;
            sh_ddra <= 8'h00;
            sh_ddrb <= 8'h00;
            sh_bank <= 8'h00;
            sh_mask <= BANKMASK_RESET;
            sh_irq  <= 8'h00;
            sh_scratch <= 8'h00;
        end
        else if (cphi2_o && hi_cnt == 1 && !cpu_rwn_i)   // write commit in PH_4
        begin
            if (win_gpio)
            begin
                case (cpu_addr_i[3:0])
                    4'h0: sh_orb  <= cpu_data_i;
                    4'h1: sh_ora  <= cpu_data_i;
                    4'h2: sh_ddrb <= cpu_data_i;
                    4'h3: sh_ddra <= cpu_data_i;
                    default: ;
                endcase
            end
            else if (win_sys)
            begin
                case (cpu_addr_i[3:0])
                    4'h0: sh_bank    <= cpu_data_i;
                    4'h1: sh_mask    <= cpu_data_i;
                    4'h2: sh_irq     <= cpu_data_i;
                    4'h3: sh_scratch <= cpu_data_i;
                    default: ;
                endcase
            end
        end
    end

    a_reset_state: assert property (@(posedge clk6x) disable iff (reset_i)
        rst_q |-> (!cphi2_o && !cpu_data_oe_o && port_a_oe_o == 8'h00 && port_b_oe_o == 8'h00))
        else
        begin
            $error("FAIL %0t: outputs not idle after reset", $time);
            err_cnt++;
        end

    a_hi_len: assert property (@(posedge clk6x) disable iff (reset_i)
        (cphi2_q && !cphi2_o) |-> hi_cnt == 3)       // three clocks high
        else
        begin
            $error("FAIL %0t: cphi2 high time wrong", $time);
            err_cnt++;
        end

    a_lo_len: assert property (@(posedge clk6x) disable iff (reset_i || rst_q)
        (cphi2_o && !cphi2_q) |-> (lo_cnt == 3 || (!run_all && lo_cnt > 3)))
        else
        begin
            $error("FAIL %0t: cphi2 low time wrong", $time);
            err_cnt++;
        end

    // cphi2 rises three clocks after run was seen high in PH_0
    a_stall: assert property (@(posedge clk6x) disable iff (reset_i)
        (cphi2_o && !cphi2_q) |-> $past(run_i, 3))
        else
        begin
            $error("FAIL %0t: cphi2 rose while run low", $time);
            err_cnt++;
        end

    a_gpio: assert property (@(posedge clk6x) disable iff (reset_i)
        port_a_o == sh_ora && port_a_oe_o == sh_ddra
        && port_b_o == sh_orb && port_b_oe_o == sh_ddrb)
        else
        begin
            $error("FAIL %0t: gpio port differs from shadow", $time);
            err_cnt++;
        end

    a_bank: assert property (@(posedge clk6x) disable iff (reset_i)
        mem_bank_o == (sh_bank & sh_mask))
        else
        begin
            $error("FAIL %0t: mem_bank_o %h", $time, mem_bank_o);
            err_cnt++;
        end

    // block wins over force and external irq
    a_irq: assert property (@(posedge clk6x) disable iff (reset_i)
        cpu_irqn_o == (sh_irq[1] ? 1'b1 : !(sh_irq[0] || !ext_irqn_i)))
        else
        begin
            $error("FAIL %0t: cpu_irqn_o wrong", $time);
            err_cnt++;
        end

    a_oe: assert property (@(posedge clk6x) disable iff (reset_i)
        cpu_data_oe_o == (cphi2_o && cpu_rwn_i && in_page))
        else
        begin
            $error("FAIL %0t: cpu_data_oe_o wrong", $time);
            err_cnt++;
        end

    a_rdata: assert property (@(posedge clk6x) disable iff (reset_i)
        (cphi2_o && cpu_rwn_i && in_page) |-> cpu_data_o == exp_read(cpu_addr_i[3:0]))
        else
        begin
            $error("FAIL %0t: read %h of %h", $time, cpu_data_o, cpu_addr_i);
            err_cnt++;
        end

endmodule

bind nora_io_top nora_io_assert #(
    .IO_PAGE        (IO_PAGE),
    .GPIO_BASE      (GPIO_BASE),
    .SYS_BASE       (SYS_BASE),
    .BANKMASK_RESET (BANKMASK_RESET)
) nora_io_assert_inst (
    .clk6x (clk6x), .reset_i (reset_i), .run_i (run_i),
    .cpu_addr_i (cpu_addr_i), .cpu_rwn_i (cpu_rwn_i), .cpu_data_i (cpu_data_i),
    .cpu_data_o (cpu_data_o), .cpu_data_oe_o (cpu_data_oe_o), .cphi2_o (cphi2_o),
    .port_a_i (port_a_i), .port_b_i (port_b_i),
    .port_a_o (port_a_o), .port_b_o (port_b_o),
    .port_a_oe_o (port_a_oe_o), .port_b_oe_o (port_b_oe_o),
    .ext_irqn_i (ext_irqn_i), .cpu_irqn_o (cpu_irqn_o), .mem_bank_o (mem_bank_o)
);

// ==== sim/nora_io_tb.sv ====
/* testbench for nora_io_top driving cpu bus cycles and run control
   checking is done by the bound assertion module */
`timescale 1ns/1ps

module nora_io_tb;
    import cpu_bus_pkg::*;
    import io_regs_pkg::*;

    // reset, 35 directed cycles, 60 random cycles, stall and tail
    localparam int PLANNED_CPU_CYCLES = 2 + 35 + 60 + 11;
    localparam int CYCLE_LIMIT = CPU_CYCLE_CLKS * PLANNED_CPU_CYCLES * 2;

    logic       clk6x = 1'b0;
    logic       reset_i;
    logic       run_i;
    cpu_addr_t  cpu_addr_i;
    logic       cpu_rwn_i;
    cpu_data_t  cpu_data_i;
    cpu_data_t  cpu_data_o;
    logic       cpu_data_oe_o;
    logic       cphi2_o;
    gpio_port_t port_a_i;
    gpio_port_t port_b_i;
    gpio_port_t port_a_o;
    gpio_port_t port_b_o;
    gpio_port_t port_a_oe_o;
    gpio_port_t port_b_oe_o;
    logic       ext_irqn_i;
    logic       cpu_irqn_o;
    bank_t      mem_bank_o;

    logic [31:0] lcg_state = 32'd62;
    int          clk_cnt = 0;
    int          timeouts = 0;
    int          assert_errs;

    nora_io_top nora_io_top_inst (
        .clk6x (clk6x), .reset_i (reset_i), .run_i (run_i),
        .cpu_addr_i (cpu_addr_i), .cpu_rwn_i (cpu_rwn_i), .cpu_data_i (cpu_data_i),
        .cpu_data_o (cpu_data_o), .cpu_data_oe_o (cpu_data_oe_o), .cphi2_o (cphi2_o),
        .port_a_i (port_a_i), .port_b_i (port_b_i),
        .port_a_o (port_a_o), .port_b_o (port_b_o),
        .port_a_oe_o (port_a_oe_o), .port_b_oe_o (port_b_oe_o),
        .ext_irqn_i (ext_irqn_i), .cpu_irqn_o (cpu_irqn_o), .mem_bank_o (mem_bank_o)
    );

    always #10 clk6x = ~clk6x;     // 20 ns clk6x

    // lcg byte from the upper half of the state
    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // one cpu cycle with inputs changed at the end of PH_0
    task automatic cpu_cycle(input cpu_addr_t addr, input logic rwn, input cpu_data_t data);
        @(posedge clk6x);
        while (!cphi2_o)
            @(posedge clk6x);
        while (cphi2_o)
            @(posedge clk6x);       // first low sample is PH_0
        cpu_addr_i <= addr;
        cpu_rwn_i  <= rwn;
        cpu_data_i <= data;
        port_a_i   <= rand_byte();  // new pin levels each cycle
        port_b_i   <= rand_byte();
    endtask

    task automatic bus_write(input cpu_addr_t addr, input cpu_data_t data);
        cpu_cycle(addr, 1'b0, data);
    endtask

    task automatic bus_read(input cpu_addr_t addr);
        cpu_cycle(addr, 1'b1, rand_byte());
    endtask

    // timeout guard
    always @(posedge clk6x)
    begin
        clk_cnt <= clk_cnt + 1;
        if (clk_cnt >= CYCLE_LIMIT)
        begin
            timeouts = timeouts + 1;
            $display("timeout: run did not end within %0d clock cycles", CYCLE_LIMIT);
            $display("errors: %0d assertion failures, %0d timeouts",
                nora_io_top_inst.nora_io_assert_inst.err_cnt, timeouts);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial
    begin
        reset_i    <= 1'b1;
        run_i      <= 1'b1;
        cpu_addr_i <= 16'h0000;
        cpu_rwn_i  <= 1'b1;
        cpu_data_i <= 8'h00;
        port_a_i   <= 8'h00;
        port_b_i   <= 8'h00;
        ext_irqn_i <= 1'b1;
        repeat (8) @(posedge clk6x);
        reset_i <= 1'b0;

        // gpio directions and outputs then readback with random pins
        bus_write(16'h9F03, rand_byte());   // ddra
        bus_write(16'h9F01, rand_byte());   // ora
        bus_write(16'h9F02, rand_byte());   // ddrb
        bus_write(16'h9F00, rand_byte());   // orb
        for (int i = 0; i < 4; i++)
            bus_read({12'h9F0, i[3:0]});

        // bank against the reset mask and then the full mask
        bus_write(16'h9F50, 8'hFF);
        bus_read(16'h9F50);
        bus_write(16'h9F51, 8'hFF);
        bus_read(16'h9F51);

        // all force/block combinations with ext irq toggling
        for (int c = 0; c < 4; c++)
        begin
            bus_write(16'h9F52, c[7:0]);
            for (int t = 0; t < 3; t++)
            begin
                ext_irqn_i <= ~ext_irqn_i;
                bus_read(16'h9F52);
            end
        end
        bus_write(16'h9F52, 8'h00);

        // decode of outside page, undecoded offsets and scratch
        bus_read(16'h1234);
        bus_read(16'h9E01);
        bus_read(16'h9F0A);
        bus_read(16'h9F80);
        bus_write(16'h9F53, 8'hA5);
        bus_read(16'h9F53);

        // random mix of reads and writes
        for (int n = 0; n < 60; n++)
        begin
            logic [7:0] r;
            logic [3:0] win;
            cpu_addr_t  a;
            r   = rand_byte();
            win = r[1] ? 4'h5 : (r[2] ? 4'h0 : 4'h3);
            a   = (r[7:6] == 2'b00) ? {8'h20, r} : {8'h9F, win, 1'b0, r[5:3]};
            cpu_cycle(a, r[0], rand_byte());
        end

        // stall until run returns
        run_i <= 1'b0;
        repeat (30) @(posedge clk6x);
        run_i <= 1'b1;
        bus_read(16'h9F01);
        bus_read(16'h9F50);
        bus_read(16'h0000);
        repeat (12) @(posedge clk6x);

        assert_errs = nora_io_top_inst.nora_io_assert_inst.err_cnt;
        $display("errors: %0d assertion failures, %0d timeouts", assert_errs, timeouts);
        if (assert_errs == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verilog/cpu_bus_ctrl.sv ====
/* cpu bus controller, cphi2 phase generator and io page decoder
   turns cpu bus cycles into slave requests and drives read data back */
`timescale 1ns/1ps

module cpu_bus_ctrl #(
    parameter logic [7:0] IO_PAGE   = 8'h9F,    // high address byte of the io page
    parameter logic [3:0] GPIO_BASE = 4'h0,     // addr[7:4] of the gpio window
    parameter logic [3:0] SYS_BASE  = 4'h5      // addr[7:4] of the sysreg window
) (
    input  logic                    clk6x,
    input  logic                    reset_i,
    input  logic                    run_i,          // low stops cpu after current cycle
    input  cpu_bus_pkg::cpu_addr_t  cpu_addr_i,
    input  logic                    cpu_rwn_i,
    input  cpu_bus_pkg::cpu_data_t  cpu_data_i,
    output cpu_bus_pkg::cpu_data_t  cpu_data_o,
    output logic                    cpu_data_oe_o,
    output logic                    cphi2_o,
    output cpu_bus_pkg::slv_req_t   slv_req_o,
    input  cpu_bus_pkg::cpu_data_t  gpio_rdata_i,
    input  cpu_bus_pkg::cpu_data_t  sys_rdata_i
);
    import cpu_bus_pkg::*;

    phase_t    phase;
    phase_t    phase_next;

    // decode of the live cpu address
    logic      page_hit;
    logic      hit_gpio;
    logic      hit_sys;

    // request state captured at setup
    slv_addr_t addr_r;
    logic      rwn_r;
    logic      page_hit_r;
    logic      sel_gpio_r;
    logic      sel_sys_r;

    cpu_data_t rdata_mux;
    cpu_data_t cpu_data_r;

    // phase sequencer, PH_0 is the only place to wait
    always_comb
    begin
        case (phase)
            PH_0:    phase_next = run_i ? PH_1 : PH_0;
            PH_1:    phase_next = PH_2;
            PH_2:    phase_next = PH_3;
            PH_3:    phase_next = PH_4;
            PH_4:    phase_next = PH_5;
            PH_5:    phase_next = PH_0;    // cycle always completes
            default: phase_next = PH_0;
        endcase
    end

    assign cphi2_o = (phase >= PH_CPHI2_RISE);  // low PH_0..2, high PH_3..5

    // page and window decode, gpio wins if both bases are equal
    always_comb
    begin
        page_hit = (cpu_addr_i[15:8] == IO_PAGE);
        hit_gpio = page_hit && (cpu_addr_i[7:4] == GPIO_BASE);
        hit_sys  = page_hit && (cpu_addr_i[7:4] == SYS_BASE) && !hit_gpio;
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            phase      <= PH_0;
            rwn_r      <= 1'b1;
            page_hit_r <= 1'b0;
            sel_gpio_r <= 1'b0;
            sel_sys_r  <= 1'b0;
        end
        else
        begin
            phase <= phase_next;
            if (phase_next == PH_SETUP)
            begin
                // address and r/w sampled on the clock into PH_2
                rwn_r      <= cpu_rwn_i;
                page_hit_r <= page_hit;
                sel_gpio_r <= hit_gpio;
                sel_sys_r  <= hit_sys;
            end
            else if (phase == PH_RELEASE)
            begin
                page_hit_r <= 1'b0;         // end of cycle
                sel_gpio_r <= 1'b0;
                sel_sys_r  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (phase_next == PH_SETUP)
            addr_r <= cpu_addr_i[3:0];      // register offset
    end

    // slave request bundle
    always_comb
    begin
        slv_req_o.addr     = addr_r;
        slv_req_o.wdata    = cpu_data_i;    // cpu drives write data in cphi2 high
        slv_req_o.rwn      = rwn_r;
        slv_req_o.wr_valid = (phase == PH_COMMIT) && !rwn_r && (sel_gpio_r || sel_sys_r);
        slv_req_o.sel_gpio = sel_gpio_r;
        slv_req_o.sel_sys  = sel_sys_r;
    end

    // read combine, undecoded offsets in the page read as IDLE_READ
    always_comb
    begin
        if (sel_gpio_r)
            rdata_mux = gpio_rdata_i;
        else if (sel_sys_r)
            rdata_mux = sys_rdata_i;
        else
            rdata_mux = IDLE_READ;
    end

    // read byte captured on PH_2 -> PH_3, held through PH_5
    always_ff @(posedge clk6x)
    begin
        if (phase == PH_SETUP)
            cpu_data_r <= rdata_mux;
    end

    assign cpu_data_o    = cpu_data_r;
    assign cpu_data_oe_o = cphi2_o && page_hit_r && rwn_r;    // only reads inside the page

endmodule

// ==== verilog/cpu_bus_pkg.sv ====
/* cpu bus definitions shared by the bus controller and its slaves
   widths, clk6x phase encoding, slave request bundle and cycle timing */
package cpu_bus_pkg;

    typedef logic [15:0] cpu_addr_t;        // 65xx address bus
    typedef logic [7:0]  cpu_data_t;        // one data byte
    typedef logic [3:0]  slv_addr_t;        // register offset inside a slave

    // six clk6x phases make one cpu cycle
    typedef enum logic [2:0] {
        PH_0,                               // cphi2 low, new address from cpu
        PH_1,
        PH_2,                               // address setup, captured on entry
        PH_3,                               // cphi2 rises
        PH_4,                               // write commit
        PH_5                                // release, cphi2 falls after this one
    } phase_t;

    // request from the bus controller, seen by every slave
    typedef struct packed {
        slv_addr_t addr;                    // offset in the selected window
        cpu_data_t wdata;                   // write byte
        logic      rwn;                     // 1 = read
        logic      wr_valid;                // one clk6x commit strobe in PH_4
        logic      sel_gpio;
        logic      sel_sys;
    } slv_req_t;

    localparam cpu_data_t IDLE_READ = 8'hFF;    // nobody answers inside the page

    // cycle timing
    localparam int     CPU_CYCLE_CLKS = 6;      // clk6x per cpu cycle
    localparam phase_t PH_SETUP       = PH_2;   // selects valid, read data captured at its end
    localparam phase_t PH_CPHI2_RISE  = PH_3;   // first phase with cphi2 high
    localparam phase_t PH_COMMIT      = PH_4;   // wr_valid phase
    localparam phase_t PH_RELEASE     = PH_5;   // selects dropped at its end

endpackage

// ==== verilog/io_regs_pkg.sv ====
/* register map of the io slaves
   offsets, reset values, gpio and bank types */
package io_regs_pkg;

    typedef logic [7:0] gpio_port_t;        // one 8 bit gpio port
    typedef logic [7:0] bank_t;             // ram bank number

    // gpio offsets, 65c22 order
    localparam cpu_bus_pkg::slv_addr_t REG_ORB  = 4'h0;
    localparam cpu_bus_pkg::slv_addr_t REG_ORA  = 4'h1;
    localparam cpu_bus_pkg::slv_addr_t REG_DDRB = 4'h2;
    localparam cpu_bus_pkg::slv_addr_t REG_DDRA = 4'h3;

    // system register offsets
    localparam cpu_bus_pkg::slv_addr_t REG_RAMBANK  = 4'h0;
    localparam cpu_bus_pkg::slv_addr_t REG_BANKMASK = 4'h1;
    localparam cpu_bus_pkg::slv_addr_t REG_IRQCTL   = 4'h2;
    localparam cpu_bus_pkg::slv_addr_t REG_SCRATCH  = 4'h3;

    localparam int IRQ_FORCE_BIT = 0;       // 1 pulls cpu irq low
    localparam int IRQ_BLOCK_BIT = 1;       // 1 keeps cpu irq high, wins over force

    localparam gpio_port_t OR_RESET         = 8'h00;
    localparam gpio_port_t DDR_RESET        = 8'h00;    // all pins input
    localparam bank_t      BANK_RESET       = 8'h00;
    localparam bank_t      BANKMASK_DEFAULT = 8'h7F;    // x16 compatible, 128 banks
    localparam logic [7:0] IRQCTL_RESET     = 8'h00;
    localparam logic [7:0] SCRATCH_RESET    = 8'h00;

endpackage

// ==== verilog/nora_io_top.sv ====
/* cpu side io of the nora system controller
   bus controller with the gpio and system register slaves */
`timescale 1ns/1ps

module nora_io_top #(
    parameter logic [7:0]         IO_PAGE        = 8'h9F,
    parameter logic [3:0]         GPIO_BASE      = 4'h0,
    parameter logic [3:0]         SYS_BASE       = 4'h5,
    parameter io_regs_pkg::bank_t BANKMASK_RESET = io_regs_pkg::BANKMASK_DEFAULT
) (
    input  logic                    clk6x,
    input  logic                    reset_i,
    input  logic                    run_i,
    // cpu bus
    input  cpu_bus_pkg::cpu_addr_t  cpu_addr_i,
    input  logic                    cpu_rwn_i,
    input  cpu_bus_pkg::cpu_data_t  cpu_data_i,
    output cpu_bus_pkg::cpu_data_t  cpu_data_o,
    output logic                    cpu_data_oe_o,  // pad enable of the data bus
    output logic                    cphi2_o,
    // gpio pads, split in/out/enable
    input  io_regs_pkg::gpio_port_t port_a_i,
    input  io_regs_pkg::gpio_port_t port_b_i,
    output io_regs_pkg::gpio_port_t port_a_o,
    output io_regs_pkg::gpio_port_t port_b_o,
    output io_regs_pkg::gpio_port_t port_a_oe_o,
    output io_regs_pkg::gpio_port_t port_b_oe_o,
    // system
    input  logic                    ext_irqn_i,
    output logic                    cpu_irqn_o,
    output io_regs_pkg::bank_t      mem_bank_o
);
    import cpu_bus_pkg::*;

    slv_req_t  slv_req;         // shared by both slaves
    cpu_data_t gpio_rdata;
    cpu_data_t sys_rdata;

    cpu_bus_ctrl #(
        .IO_PAGE   (IO_PAGE),
        .GPIO_BASE (GPIO_BASE),
        .SYS_BASE  (SYS_BASE)
    ) cpu_bus_ctrl_inst (
        .clk6x         (clk6x),
        .reset_i       (reset_i),
        .run_i         (run_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_rwn_i     (cpu_rwn_i),
        .cpu_data_i    (cpu_data_i),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o),
        .cphi2_o       (cphi2_o),
        .slv_req_o     (slv_req),
        .gpio_rdata_i  (gpio_rdata),
        .sys_rdata_i   (sys_rdata)
    );

    via_gpio via_gpio_inst (
        .clk6x       (clk6x),
        .reset_i     (reset_i),
        .slv_req_i   (slv_req),
        .rdata_o     (gpio_rdata),
        .port_a_i    (port_a_i),
        .port_b_i    (port_b_i),
        .port_a_o    (port_a_o),
        .port_b_o    (port_b_o),
        .port_a_oe_o (port_a_oe_o),
        .port_b_oe_o (port_b_oe_o)
    );

    sys_regs #(
        .BANKMASK_RESET (BANKMASK_RESET)
    ) sys_regs_inst (
        .clk6x      (clk6x),
        .reset_i    (reset_i),
        .slv_req_i  (slv_req),
        .rdata_o    (sys_rdata),
        .ext_irqn_i (ext_irqn_i),
        .cpu_irqn_o (cpu_irqn_o),
        .mem_bank_o (mem_bank_o)
    );

endmodule

// ==== verilog/sys_regs.sv ====
/* system register block, ram bank with mask, irq force/block and scratch
   combines the external irq line into the cpu irq */
`timescale 1ns/1ps

module sys_regs #(
    parameter io_regs_pkg::bank_t BANKMASK_RESET = 8'h7F   // x16 style 128 banks
) (
    input  logic                    clk6x,
    input  logic                    reset_i,
    input  cpu_bus_pkg::slv_req_t   slv_req_i,
    output cpu_bus_pkg::cpu_data_t  rdata_o,
    input  logic                    ext_irqn_i,     // wired-or irq from the board
    output logic                    cpu_irqn_o,
    output io_regs_pkg::bank_t      mem_bank_o
);
    import cpu_bus_pkg::*;
    import io_regs_pkg::*;

    bank_t     rambank;
    bank_t     bankmask;
    cpu_data_t irqctl;      // only bits 0 and 1 act, all bits read back
    cpu_data_t scratch;
    logic      wr_en;
    logic      irq_force;
    logic      irq_block;

    assign wr_en = slv_req_i.wr_valid && slv_req_i.sel_sys;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            rambank  <= BANK_RESET;
            bankmask <= BANKMASK_RESET;
            irqctl   <= IRQCTL_RESET;   // ext irq passes through
            scratch  <= SCRATCH_RESET;
        end
        else if (wr_en)
        begin
            case (slv_req_i.addr)
                REG_RAMBANK:  rambank  <= slv_req_i.wdata;
                REG_BANKMASK: bankmask <= slv_req_i.wdata;
                REG_IRQCTL:   irqctl   <= slv_req_i.wdata;
                REG_SCRATCH:  scratch  <= slv_req_i.wdata;
                default:      ;
            endcase
        end
    end

    always_comb
    begin
        case (slv_req_i.addr)
            REG_RAMBANK:  rdata_o = rambank;    // unmasked value
            REG_BANKMASK: rdata_o = bankmask;
            REG_IRQCTL:   rdata_o = irqctl;
            REG_SCRATCH:  rdata_o = scratch;
            default:      rdata_o = IDLE_READ;
        endcase
    end

    assign mem_bank_o = rambank & bankmask;

    assign irq_force = irqctl[IRQ_FORCE_BIT];
    assign irq_block = irqctl[IRQ_BLOCK_BIT];

    // active low, block wins over force and ext
    assign cpu_irqn_o = irq_block | (ext_irqn_i & ~irq_force);

endmodule

// ==== verilog/via_gpio.sv ====
/* simplified 65c22, two 8 bit gpio ports
   output and direction register per port, no timers or handshake lines */
`timescale 1ns/1ps

module via_gpio (
    input  logic                    clk6x,
    input  logic                    reset_i,
    input  cpu_bus_pkg::slv_req_t   slv_req_i,
    output cpu_bus_pkg::cpu_data_t  rdata_o,
    input  io_regs_pkg::gpio_port_t port_a_i,
    input  io_regs_pkg::gpio_port_t port_b_i,
    output io_regs_pkg::gpio_port_t port_a_o,
    output io_regs_pkg::gpio_port_t port_b_o,
    output io_regs_pkg::gpio_port_t port_a_oe_o,
    output io_regs_pkg::gpio_port_t port_b_oe_o
);
    import cpu_bus_pkg::*;
    import io_regs_pkg::*;

    gpio_port_t ora;        // output reg a
    gpio_port_t orb;
    gpio_port_t ddra;       // 1 = output
    gpio_port_t ddrb;
    logic       wr_en;

    // per bit readback, driven bits from the register and the rest from the pin
    function automatic gpio_port_t port_read(
        input gpio_port_t out_reg,
        input gpio_port_t dir,
        input gpio_port_t pins
    );
        port_read = (out_reg & dir) | (pins & ~dir);
    endfunction

    assign wr_en = slv_req_i.wr_valid && slv_req_i.sel_gpio;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            ora  <= OR_RESET;
            orb  <= OR_RESET;
            ddra <= DDR_RESET;      // outputs off after reset
            ddrb <= DDR_RESET;
        end
        else if (wr_en)
        begin
            case (slv_req_i.addr)
                REG_ORB:  orb  <= slv_req_i.wdata;
                REG_ORA:  ora  <= slv_req_i.wdata;
                REG_DDRB: ddrb <= slv_req_i.wdata;
                REG_DDRA: ddra <= slv_req_i.wdata;
                default:  ;     // unmapped offsets ignore writes
            endcase
        end
    end

    // combinational read of the addressed register
    always_comb
    begin
        case (slv_req_i.addr)
            REG_ORB:  rdata_o = port_read(orb, ddrb, port_b_i);
            REG_ORA:  rdata_o = port_read(ora, ddra, port_a_i);
            REG_DDRB: rdata_o = ddrb;
            REG_DDRA: rdata_o = ddra;
            default:  rdata_o = IDLE_READ;
        endcase
    end

    assign port_a_o    = ora;
    assign port_b_o    = orb;
    assign port_a_oe_o = ddra;     // pad enable per bit
    assign port_b_oe_o = ddrb;

endmodule
